//--- sources.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
common/bypassIf.sv
core/fetchStage.sv
core/decodeStage.sv
core/executeStage.sv
core/memWbStage.sv
src/bigCore.sv
verif/bigCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing -Wno-fatal -f sources.f --top-module bigCoreTb -o bigCoreSim &&
  ./obj_dir/bigCoreSim | tee /dev/stderr | grep -q "^Done: no errors$" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }

//--- verif/bigCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module bigCoreTb;
  import isaPkg::*;

  localparam int IMEM_WORDS = 1024;
  localparam int DMEM_WORDS = 256;
  localparam int INIT_WORDS = 62;                      // LUI plus ADDI for x1..x31
  localparam int BODY_END   = INIT_WORDS + 300;        // First of the final stores
  localparam int FINAL_BASE = 512;                     // Register dump area
  localparam int TIMEOUT_CYCLES = 5000;
  localparam logic [31:0] SELF_LOOP = 32'h0000_006F;   // JAL x0,0

  logic                  Clk;
  logic                  arstN;
  logic [`CORE_XLEN-1:0] pc;
  logic [`CORE_XLEN-1:0] instr;
  logic [`CORE_XLEN-1:0] dMemAddr;
  logic [`CORE_XLEN-1:0] dMemWrData;
  logic                  dMemWrEn;
  logic                  dMemRdEn;
  logic [`CORE_XLEN-1:0] dMemRdData;

  int          seed;
  int          startCycles;
  logic [31:0] imem    [0:IMEM_WORDS-1];
  logic [31:0] dmem    [0:DMEM_WORDS-1];   // Memory seen by the DUT
  logic [31:0] refMem  [0:DMEM_WORDS-1];   // Memory of the ISA model
  logic [31:0] refRegs [0:31];
  bit          landed  [0:IMEM_WORDS-1];   // Slot is a branch or jump target
  logic [4:0]  recent  [0:2];              // Last destinations, for dependent sources
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] fetchPc;                    // pc of the previous cycle
  logic [31:0] rdPending;

  bigCore dut (
    .Clk        (Clk),
    .arstN      (arstN),
    .pc         (pc),
    .instr      (instr),
    .dMemAddr   (dMemAddr),
    .dMemWrData (dMemWrData),
    .dMemWrEn   (dMemWrEn),
    .dMemRdEn   (dMemRdEn),
    .dMemRdData (dMemRdData)
  );

  always #50 Clk = ~Clk;  // 100 ns period

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////
  function automatic int randBelow(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [4:0] pickSrc();
    if (randBelow(2) == 0) begin
      return recent[randBelow(3)];  // Distance 1 to 3 dependency
    end
    return 5'(randBelow(32));
  endfunction

  function automatic logic [31:0] fillWord(input int w);
    return (32'(w) * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, R_OP};
  endfunction

  function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // SW
  endfunction

  function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
  endfunction

  function automatic logic [31:0] encU(input logic [31:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm[31:12], rd, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  // Random program with forward-only control flow
  task automatic genProgram();
    int          i;
    int          t;
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] r;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i]   = `CORE_NOP;
      landed[i] = 1'b0;
    end
    for (i = 1; i < 32; i++) begin
      r = $random(seed);
      imem[2*i-2] = encU(r, 5'(i), LUI);
      imem[2*i-1] = encI(r, 5'(i), 3'b000, 5'(i), I_OP);  // Distance 1 on purpose
    end
    i = INIT_WORDS;
    while (i < BODY_END) begin
      kind = randBelow(16);
      rd   = 5'(randBelow(32));
      rs1  = pickSrc();
      rs2  = pickSrc();
      f3   = 3'(randBelow(8));
      r    = $random(seed);
      if (kind < 6) begin
        imem[i] = encR({1'b0, r[0] & ((f3 == 3'b000) | (f3 == 3'b101)), 5'b0},
                       rs2, rs1, f3, rd);
      end else if (kind < 9) begin
        if (f3 == 3'b001) begin
          r = {27'b0, r[4:0]};                        // SLLI shamt only
        end else if (f3 == 3'b101) begin
          r = {20'b0, 1'b0, r[10], 5'b0, r[4:0]};     // SRLI or SRAI
        end
        imem[i] = encI(r, rs1, f3, rd, I_OP);
      end else if (kind == 9) begin
        imem[i] = encU(r, rd, r[31] ? LUI : AUIPC);
      end else if (kind == 10) begin
        imem[i] = encI(32'(4 * randBelow(64)), 5'd0, 3'b010, rd, LOAD);
      end else if (kind == 11) begin
        imem[i] = encS(32'(4 * randBelow(64)), rs2, 5'd0);
      end else if (kind < 14) begin
        t = i + 1 + randBelow(8);
        if (t > BODY_END) begin
          t = BODY_END;
        end
        landed[t] = 1'b1;
        if (kind == 12) begin
          f3 = 3'(randBelow(6));
          if (f3 > 3'd1) begin
            f3 = f3 + 3'd2;                           // Skip the unused funct3 codes
          end
          imem[i] = encB(32'(4 * (t - i)), rs2, rs1, f3);
        end else begin
          imem[i] = encJ(32'(4 * (t - i)), rd);
        end
      end else if ((i + 1 < BODY_END) && !landed[i + 1]) begin
        // AUIPC then JALR, nobody may land between them
        t = i + 2 + randBelow(6);
        if (t > BODY_END) begin
          t = BODY_END;
        end
        landed[t] = 1'b1;
        rs1       = 5'(1 + randBelow(31));
        imem[i]   = encU(32'd0, rs1, AUIPC);
        i++;
        imem[i]   = encI(32'(4 * (t - i + 1)), rs1, 3'b000, rd, JALR);
      end
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = rd;
      i++;
    end
    for (i = 1; i < 32; i++) begin
      imem[BODY_END + i - 1] = encS(32'(FINAL_BASE + 4 * i), 5'(i), 5'd0);
    end
    imem[BODY_END + 31] = SELF_LOOP;
  endtask

  //////////////////////////////////////////////////////////////////////
  // ISA reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101: begin
        if (alt) begin
          return $signed(x) >>> y[4:0];
        end
        return x >> y[4:0];
      end
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  // Runs the program in order and queues every store
  task automatic runModel();
    logic [31:0] mpc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] addr;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic        wr;
    logic        taken;
    int          k;
    for (k = 0; k < 32; k++) begin
      refRegs[k] = '0;
    end
    for (k = 0; k < DMEM_WORDS; k++) begin
      refMem[k] = fillWord(k);
    end
    mpc = `CORE_RESET_PC;
    k   = 0;
    while ((imem[mpc[11:2]] != SELF_LOOP) && (k < 4000)) begin
      ins    = imem[mpc[11:2]];
      a      = refRegs[ins[19:15]];
      b      = refRegs[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      nextPc = mpc + 32'd4;
      res    = '0;
      wr     = 1'b1;
      taken  = 1'b0;
      case (ins[6:0])
        LUI:   res = {ins[31:12], 12'b0};
        AUIPC: res = mpc + {ins[31:12], 12'b0};
        JAL: begin
          res    = mpc + 32'd4;
          nextPc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        JALR: begin
          res    = mpc + 32'd4;
          nextPc = (a + immI) & ~32'd1;
        end
        BRANCH: begin
          wr = 1'b0;
          case (ins[14:12])
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) begin
            nextPc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        LOAD: begin
          addr = a + immI;
          res  = refMem[addr[9:2]];
        end
        STORE: begin
          wr   = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          refMem[addr[9:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
        end
        I_OP:    res = aluRef(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, immI);
        R_OP:    res = aluRef(ins[14:12], ins[30], a, b);
        default: wr = 1'b0;                           // FENCE and NOP slots
      endcase
      if (wr && (ins[11:7] != 5'd0)) begin
        refRegs[ins[11:7]] = res;
      end
      mpc = nextPc;
      k++;
    end
    if (k >= 4000) begin
      $display("Reference model never reached the final self-loop");
      $display("Done: errors found");
      $fatal(1, "Model runaway");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic observeStore(input logic [31:0] addr, input logic [31:0] data);
    if (expAddr.size() == 0) begin
      $display("Unexpected data-memory write to %h after the last expected store", addr);
      $display("Done: errors found");
      $fatal(1, "Extra store");
    end else begin
      checkValue("store address", addr, expAddr.pop_front());
      checkValue("store data", data, expData.pop_front());
    end
  endtask

  // Memory models and store monitor, all on the falling edge
  always @(negedge Clk) begin
    if (!arstN || (startCycles < INIT_WORDS + 2)) begin
      checkValue("memory enables at start-up", {30'b0, dMemRdEn, dMemWrEn}, 32'd0);
    end
    if (arstN) begin
      startCycles++;
    end
    instr      = imem[fetchPc[11:2]];  // Answer for last cycle's pc
    fetchPc    = pc;
    dMemRdData = rdPending;            // Read presented one cycle ago
    if (dMemRdEn) begin
      rdPending = dmem[dMemAddr[9:2]];
    end
    if (dMemWrEn) begin
      dmem[dMemAddr[9:2]] = dMemWrData;
      observeStore(dMemAddr, dMemWrData);
    end
  end

  initial begin
    int w;
    int waitCycles;
    Clk         = 1'b0;
    arstN       = 1'b0;
    instr       = `CORE_NOP;
    dMemRdData  = '0;
    fetchPc     = '0;
    rdPending   = '0;
    startCycles = 0;
    seed        = 55;
    recent[0]   = 5'd0;
    recent[1]   = 5'd0;
    recent[2]   = 5'd0;
    for (w = 0; w < DMEM_WORDS; w++) begin
      dmem[w] = fillWord(w);
    end
    genProgram();
    runModel();
    repeat (2) @(negedge Clk);
    arstN = 1'b1;
    checkValue("pc after reset", pc, `CORE_RESET_PC);
    waitCycles = 0;
    while ((expAddr.size() != 0) && (waitCycles < TIMEOUT_CYCLES)) begin
      @(negedge Clk);
      waitCycles++;
    end
    if (expAddr.size() != 0) begin
      $display("Timeout: %0d stores still missing after %0d cycles",
               expAddr.size(), waitCycles);
      $display("Done: errors found");
      $fatal(1, "Timeout");
    end else begin
      // Self-loop must stay quiet
      for (w = 0; w < 20; w++) begin
        @(negedge Clk);
      end
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src/bigCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module bigCore (
  input  wire                   Clk,
  input  wire                   arstN,
  // Instruction memory
  output logic [`CORE_XLEN-1:0] pc,
  input  wire [`CORE_XLEN-1:0]  instr,
  // Data memory
  output logic [`CORE_XLEN-1:0] dMemAddr,
  output logic [`CORE_XLEN-1:0] dMemWrData,
  output logic                  dMemWrEn,
  output logic                  dMemRdEn,
  input  wire [`CORE_XLEN-1:0]  dMemRdData
);
  import pipePkg::*;

  logic                  stall;
  logic                  redirect;
  logic [`CORE_XLEN-1:0] redirectPc;
  logic [`CORE_XLEN-1:0] instrQ101;
  logic [`CORE_XLEN-1:0] pcQ101;
  logic [`CORE_XLEN-1:0] pcPlus4Q101;
  exStageT               exQ102;
  memStageT              memQ103;

  bypassIf bypass ();  // Q103H and Q104H results

  // Q100H
  fetchStage uFetch (
    .Clk         (Clk),
    .arstN       (arstN),
    .stall       (stall),
    .redirect    (redirect),
    .redirectPc  (redirectPc),
    .pc          (pc),
    .instr       (instr),
    .flushQ101   (),
    .instrQ101   (instrQ101),
    .pcQ101      (pcQ101),
    .pcPlus4Q101 (pcPlus4Q101)
  );

  // Q101H
  decodeStage uDecode (
    .Clk         (Clk),
    .arstN       (arstN),
    .instrQ101   (instrQ101),
    .pcQ101      (pcQ101),
    .pcPlus4Q101 (pcPlus4Q101),
    .stall       (stall),
    .bypass      (bypass.regRead),
    .exOut       (exQ102)
  );

  // Q102H
  executeStage uExecute (
    .Clk        (Clk),
    .arstN      (arstN),
    .exIn       (exQ102),
    .bypass     (bypass.forward),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .memOut     (memQ103)
  );

  // Q103H and Q104H
  memWbStage uMemWb (
    .Clk        (Clk),
    .arstN      (arstN),
    .memIn      (memQ103),
    .dMemAddr   (dMemAddr),
    .dMemWrData (dMemWrData),
    .dMemWrEn   (dMemWrEn),
    .dMemRdEn   (dMemRdEn),
    .dMemRdData (dMemRdData),
    .bypass     (bypass.source)
  );

endmodule

`default_nettype wire

//--- core/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module memWbStage (
  input  wire                    Clk,
  input  wire                    arstN,
  input  wire pipePkg::memStageT memIn,
  output logic [`CORE_XLEN-1:0]  dMemAddr,
  output logic [`CORE_XLEN-1:0]  dMemWrData,
  output logic                   dMemWrEn,
  output logic                   dMemRdEn,
  input  wire [`CORE_XLEN-1:0]   dMemRdData,  // Valid in Q104H
  bypassIf.source                bypass
);

  logic [`CORE_XLEN-1:0]      aluOutQ104;
  logic [`CORE_XLEN-1:0]      pcPlus4Q104;
  logic [`CORE_REG_IDX_W-1:0] regDstQ104;
  logic                       regWrEnQ104;
  logic                       selDMemWbQ104;
  logic                       selRegWrPcQ104;

  // Q103H memory access
  assign dMemAddr   = memIn.aluOut;
  assign dMemWrData = memIn.storeData;
  assign dMemWrEn   = memIn.dMemWrEn;
  assign dMemRdEn   = memIn.selDMemWb;

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      regDstQ104     <= '0;
      regWrEnQ104    <= 1'b0;
      selDMemWbQ104  <= 1'b0;
      selRegWrPcQ104 <= 1'b0;
    end else begin
      regDstQ104     <= memIn.regDst;
      regWrEnQ104    <= memIn.regWrEn;
      selDMemWbQ104  <= memIn.selDMemWb;
      selRegWrPcQ104 <= memIn.selRegWrPc;
    end
  end

  always_ff @(posedge Clk) begin
    aluOutQ104  <= memIn.aluOut;
    pcPlus4Q104 <= memIn.pcPlus4;
  end

  // Results back to decode and execute
  assign bypass.rd103     = memIn.regDst;
  assign bypass.wrEn103   = memIn.regWrEn;
  assign bypass.aluOut103 = memIn.selRegWrPc ? memIn.pcPlus4 : memIn.aluOut;  // Link for jumps
  assign bypass.rd104     = regDstQ104;
  assign bypass.wrEn104   = regWrEnQ104;
  assign bypass.wrData104 = selRegWrPcQ104 ? pcPlus4Q104 :
                            selDMemWbQ104  ? dMemRdData  :  // LW result
                                             aluOutQ104;

endmodule

`default_nettype wire

//--- core/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module executeStage (
  input  wire                   Clk,
  input  wire                   arstN,
  input  wire pipePkg::exStageT exIn,
  bypassIf.forward              bypass,
  output logic                  redirect,
  output logic [`CORE_XLEN-1:0] redirectPc,
  output pipePkg::memStageT     memOut      // Q103H payload
);
  import isaPkg::*;
  import pipePkg::*;

  logic [`CORE_XLEN-1:0] opData1;   // Register operands after forwarding
  logic [`CORE_XLEN-1:0] opData2;
  logic [`CORE_XLEN-1:0] aluIn1;
  logic [`CORE_XLEN-1:0] aluIn2;
  logic [4:0]            shamt;
  logic [`CORE_XLEN-1:0] aluOut;
  logic                  eq;
  logic                  ltS;
  logic                  ltU;
  logic                  branchTaken;
  memStageT              memNext;

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////
  function automatic logic [`CORE_XLEN-1:0] fwdOperand(
    input logic [`CORE_REG_IDX_W-1:0] src,
    input logic [`CORE_XLEN-1:0]      regData
  );
    if (src == '0) begin
      return regData;                    // Already zero
    end
    if (bypass.wrEn103 && (bypass.rd103 == src)) begin
      return bypass.aluOut103;           // Newest producer wins
    end
    if (bypass.wrEn104 && (bypass.rd104 == src)) begin
      return bypass.wrData104;
    end
    return regData;
  endfunction

  assign opData1 = fwdOperand(exIn.rs1, exIn.rdData1);
  assign opData2 = fwdOperand(exIn.rs2, exIn.rdData2);

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  assign aluIn1 = exIn.ctrl.selAluPc  ? exIn.pc        : opData1;
  assign aluIn2 = exIn.ctrl.selAluImm ? exIn.immediate : opData2;
  assign shamt  = aluIn2[4:0];

  always_comb begin
    unique case (exIn.ctrl.aluOp)
      SUB:     aluOut = aluIn1 - aluIn2;
      SLT:     aluOut = `CORE_XLEN'($signed(aluIn1) < $signed(aluIn2));
      SLTU:    aluOut = `CORE_XLEN'(aluIn1 < aluIn2);
      SLL:     aluOut = aluIn1 << shamt;
      SRL:     aluOut = aluIn1 >> shamt;
      SRA:     aluOut = $signed(aluIn1) >>> shamt;
      XOR:     aluOut = aluIn1 ^ aluIn2;
      OR:      aluOut = aluIn1 | aluIn2;
      AND:     aluOut = aluIn1 & aluIn2;
      default: aluOut = aluIn1 + aluIn2;  // ADD and all address math
    endcase
    if (exIn.ctrl.ctrlLui) begin
      aluOut = aluIn2;                    // LUI takes the immediate as is
    end
  end

  // Branch comparator on the forwarded operands
  assign eq  = (opData1 == opData2);
  assign ltS = ($signed(opData1) < $signed(opData2));
  assign ltU = (opData1 < opData2);

  always_comb begin
    unique case (exIn.ctrl.branchOp)
      BEQ:     branchTaken = eq;
      BNE:     branchTaken = !eq;
      BLT:     branchTaken = ltS;
      BGE:     branchTaken = !ltS;
      BLTU:    branchTaken = ltU;
      BGEU:    branchTaken = !ltU;
      default: branchTaken = 1'b0;
    endcase
  end

  assign redirect   = exIn.ctrl.selNextPcJump || (exIn.ctrl.selNextPcBranch && branchTaken);
  assign redirectPc = {aluOut[`CORE_XLEN-1:1], 1'b0};  // JALR clears bit 0

  assign memNext = '{
    aluOut:     aluOut,
    storeData:  opData2,
    pcPlus4:    exIn.pcPlus4,
    regDst:     exIn.ctrl.regDst,
    regWrEn:    exIn.ctrl.regWrEn,
    dMemWrEn:   exIn.ctrl.dMemWrEn,
    selDMemWb:  exIn.ctrl.selDMemWb,
    selRegWrPc: exIn.ctrl.selRegWrPc
  };

  // Q102H to Q103H
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      memOut <= '0;
    end else begin
      memOut <= memNext;
    end
  end

endmodule

`default_nettype wire

//--- core/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module decodeStage (
  input  wire                   Clk,
  input  wire                   arstN,
  input  wire [`CORE_XLEN-1:0]  instrQ101,
  input  wire [`CORE_XLEN-1:0]  pcQ101,
  input  wire [`CORE_XLEN-1:0]  pcPlus4Q101,
  output logic                  stall,
  bypassIf.regRead              bypass,
  output pipePkg::exStageT      exOut       // Q102H payload
);
  import isaPkg::*;
  import pipePkg::*;

  opcodeT                     opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [`CORE_REG_IDX_W-1:0] rs1;
  logic [`CORE_REG_IDX_W-1:0] rs2;
  immT                        immSel;
  logic [`CORE_XLEN-1:0]      imm;
  ctrlT                       ctrl;
  exStageT                    exNext;
  logic [`CORE_XLEN-1:0]      regFile [1:`CORE_NUM_REGS-1];  // No storage for x0

  assign opcode = opcodeT'(instrQ101[6:0]);
  assign funct3 = instrQ101[14:12];
  assign funct7 = instrQ101[31:25];
  assign rs1    = instrQ101[19:15];
  assign rs2    = instrQ101[24:20];

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    ctrl                 = '0;
    ctrl.selNextPcJump   = (opcode == JAL) || (opcode == JALR);
    ctrl.selNextPcBranch = (opcode == BRANCH);
    ctrl.selRegWrPc      = (opcode == JAL) || (opcode == JALR);  // Link is pc + 4
    ctrl.selAluPc        = (opcode == JAL) || (opcode == BRANCH) || (opcode == AUIPC);
    ctrl.selAluImm       = (opcode != R_OP);
    ctrl.selDMemWb       = (opcode == LOAD);
    ctrl.ctrlLui         = (opcode == LUI);
    ctrl.regWrEn         = (opcode == LUI)  || (opcode == AUIPC) || (opcode == JAL) ||
                           (opcode == JALR) || (opcode == LOAD)  || (opcode == I_OP) ||
                           (opcode == R_OP);
    ctrl.dMemWrEn        = (opcode == STORE);
    ctrl.branchOp        = branchT'(funct3);
    ctrl.regDst          = instrQ101[11:7];
    ctrl.aluOp           = ADD;  // Address and target adds
    if ((opcode == R_OP) || (opcode == I_OP)) begin
      unique case (funct3)
        3'b000:  ctrl.aluOp = ((opcode == R_OP) && funct7[5]) ? SUB : ADD;
        3'b001:  ctrl.aluOp = SLL;
        3'b010:  ctrl.aluOp = SLT;
        3'b011:  ctrl.aluOp = SLTU;
        3'b100:  ctrl.aluOp = XOR;
        3'b101:  ctrl.aluOp = funct7[5] ? SRA : SRL;  // Same bit for SRAI
        3'b110:  ctrl.aluOp = OR;
        default: ctrl.aluOp = AND;
      endcase
    end
  end

  // Immediate generator
  always_comb begin
    unique case (opcode)
      LUI, AUIPC: immSel = U_TYPE;
      JAL:        immSel = J_TYPE;
      BRANCH:     immSel = B_TYPE;
      STORE:      immSel = S_TYPE;
      default:    immSel = I_TYPE;  // JALR LOAD I_OP
    endcase
    unique case (immSel)
      U_TYPE:  imm = {instrQ101[31:12], 12'b0};
      S_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[31:25], instrQ101[11:7]};
      B_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[7], instrQ101[30:25],
                      instrQ101[11:8], 1'b0};
      J_TYPE:  imm = {{12{instrQ101[31]}}, instrQ101[19:12], instrQ101[20],
                      instrQ101[30:21], 1'b0};
      default: imm = {{20{instrQ101[31]}}, instrQ101[31:20]};
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge Clk) begin
    if (bypass.wrEn104 && (bypass.rd104 != '0)) begin
      regFile[bypass.rd104] <= bypass.wrData104;
    end
  end

  function automatic logic [`CORE_XLEN-1:0] readReg(input logic [`CORE_REG_IDX_W-1:0] idx);
    if (idx == '0) begin
      return '0;                 // x0 hard-wired
    end
    if (bypass.wrEn104 && (bypass.rd104 == idx)) begin
      return bypass.wrData104;   // Write in this same cycle
    end
    return regFile[idx];
  endfunction

  // Load in Q102H feeding this instruction
  assign stall = exOut.ctrl.selDMemWb && (exOut.ctrl.regDst != '0) &&
                 ((rs1 == exOut.ctrl.regDst) || (rs2 == exOut.ctrl.regDst));

  assign exNext = '{
    pc:        pcQ101,
    pcPlus4:   pcPlus4Q101,
    immediate: imm,
    rs1:       rs1,
    rs2:       rs2,
    rdData1:   readReg(rs1),
    rdData2:   readReg(rs2),
    ctrl:      stall ? '0 : ctrl  // Bubble while the load completes
  };

  // Q101H to Q102H
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      exOut <= '0;
    end else begin
      exOut <= exNext;
    end
  end

endmodule

`default_nettype wire

//--- core/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

module fetchStage (
  input  wire                    Clk,
  input  wire                    arstN,
  input  wire                    stall,       // Load-use hazard in decode
  input  wire                    redirect,    // Taken branch or jump in Q102H
  input  wire [`CORE_XLEN-1:0]   redirectPc,
  output logic [`CORE_XLEN-1:0]  pc,          // Q100H address to instruction memory
  input  wire [`CORE_XLEN-1:0]   instr,       // Word for last cycle's pc
  output logic                   flushQ101,
  output logic [`CORE_XLEN-1:0]  instrQ101,
  output logic [`CORE_XLEN-1:0]  pcQ101,
  output logic [`CORE_XLEN-1:0]  pcPlus4Q101
);

  logic [`CORE_XLEN-1:0] pcPlus4;
  logic [`CORE_XLEN-1:0] instrPrev;  // Raw word seen one cycle ago
  logic                  flushDly;   // Second flushed slot
  logic                  stallDly;   // Replay slot

  assign pcPlus4 = pc + `CORE_XLEN'(4);

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      pc       <= `CORE_RESET_PC;
      flushDly <= 1'b1;  // First word after reset is stale
      stallDly <= 1'b0;
    end else begin
      if (redirect || !stall) begin
        pc <= redirect ? redirectPc : pcPlus4;  // Freeze on stall
      end
      flushDly <= redirect;
      stallDly <= stall;
    end
  end

  // Q100H to Q101H copies of the PC hold together with it
  always_ff @(posedge Clk) begin
    if (!stall) begin
      pcQ101      <= pc;
      pcPlus4Q101 <= pcPlus4;
    end
    instrPrev <= instr;
  end

  // Kill the two words behind a redirect
  assign flushQ101 = redirect || flushDly;
  assign instrQ101 = flushQ101 ? `CORE_NOP :
                     stallDly  ? instrPrev :  // Stalled word fetched again
                                 instr;

endmodule

`default_nettype wire

//--- common/bypassIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "coreParams.svh"

interface bypassIf;
  logic [`CORE_REG_IDX_W-1:0] rd103;      // Q103H destination
  logic                       wrEn103;
  logic [`CORE_XLEN-1:0]      aluOut103;  // Q103H result ready to forward
  logic [`CORE_REG_IDX_W-1:0] rd104;      // Q104H destination
  logic                       wrEn104;
  logic [`CORE_XLEN-1:0]      wrData104;  // Final write-back value

  // Driven by memory and write-back
  modport source  (output rd103, wrEn103, aluOut103, rd104, wrEn104, wrData104);
  // Register file write port and read bypass
  modport regRead (input rd104, wrEn104, wrData104);
  // Operand forwarding in execute
  modport forward (input rd103, wrEn103, aluOut103, rd104, wrEn104, wrData104);
endinterface

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none
`include "coreParams.svh"

package pipePkg;

  // Decoded control bits of one instruction
  typedef struct packed {
    logic                       selNextPcJump;    // JAL or JALR
    logic                       selNextPcBranch;  // Conditional branch
    logic                       selRegWrPc;       // Write back the link value
    logic                       selAluPc;         // ALU operand A is the PC
    logic                       selAluImm;        // ALU operand B is the immediate
    logic                       selDMemWb;        // Load result goes to rd
    logic                       ctrlLui;          // Pass immediate through
    logic                       regWrEn;
    logic                       dMemWrEn;
    isaPkg::aluOpT              aluOp;
    isaPkg::branchT             branchOp;
    logic [`CORE_REG_IDX_W-1:0] regDst;
  } ctrlT;

  // Q102H payload into execute
  typedef struct packed {
    logic [`CORE_XLEN-1:0]      pc;
    logic [`CORE_XLEN-1:0]      pcPlus4;
    logic [`CORE_XLEN-1:0]      immediate;
    logic [`CORE_REG_IDX_W-1:0] rs1;
    logic [`CORE_REG_IDX_W-1:0] rs2;
    logic [`CORE_XLEN-1:0]      rdData1;   // Before forwarding
    logic [`CORE_XLEN-1:0]      rdData2;
    ctrlT                       ctrl;
  } exStageT;

  // Q103H payload into memory access
  typedef struct packed {
    logic [`CORE_XLEN-1:0]      aluOut;    // Result or data address
    logic [`CORE_XLEN-1:0]      storeData;
    logic [`CORE_XLEN-1:0]      pcPlus4;
    logic [`CORE_REG_IDX_W-1:0] regDst;
    logic                       regWrEn;
    logic                       dMemWrEn;
    logic                       selDMemWb;
    logic                       selRegWrPc;
  } memStageT;

endpackage

`default_nettype wire

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

  // Major opcodes from instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,  // LW only
    STORE  = 7'b0100011,  // SW only
    I_OP   = 7'b0010011,
    R_OP   = 7'b0110011,
    FENCE  = 7'b0001111   // Executes as a NOP
  } opcodeT;

  // ALU function select
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLT  = 4'd2,
    SLTU = 4'd3,
    SLL  = 4'd4,
    SRL  = 4'd5,
    SRA  = 4'd6,
    XOR  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } aluOpT;

  // Branch kinds match funct3 directly
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchT;

  // Immediate formats
  typedef enum logic [2:0] {
    I_TYPE = 3'd0,
    S_TYPE = 3'd1,
    B_TYPE = 3'd2,
    U_TYPE = 3'd3,
    J_TYPE = 3'd4
  } immT;

endpackage

`default_nettype wire

//--- common/coreParams.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and address width
`define CORE_XLEN      32

// Architectural register file
`define CORE_NUM_REGS  32
`define CORE_REG_IDX_W 5

// First fetch address out of reset
`define CORE_RESET_PC  32'h0000_0000

// ADDI x0,x0,0 used for bubbles and flushed slots
`define CORE_NOP       32'h0000_0013

`endif
